/* logic/queue_states_params.svh */
//////////////////////////////
// Queue state sizes
//////////////////////////////

`ifndef QUEUE_STATES_PARAMS_SVH
`define QUEUE_STATES_PARAMS_SVH

// Queue and page geometry
`define QS_NUM_QUEUES      8
`define QS_NUM_PAGES       16
`define QS_WORDS_PER_PAGE  8
`define QS_BYTES_PER_WORD  64

// Packet limits, one MTU never spans more than a page
`define QS_MTU_BYTES       512
`define QS_MIN_BYTES       64

// Width of one byte occupancy counter
`define QS_OCC_BITS        16

`endif

/* logic/queue_states_pkg.sv */
//////////////////////////////
// Queue state types
//////////////////////////////

`default_nettype none

`include "queue_states_params.svh"

package queue_states_pkg;

    // Indexes
    typedef logic [$clog2(`QS_NUM_QUEUES)-1:0] queue_idx_t;
    typedef logic [$clog2(`QS_NUM_PAGES)-1:0] page_idx_t;

    // Offset of a word inside its page
    typedef logic [$clog2(`QS_WORDS_PER_PAGE)-1:0] word_ptr_t;

    // Packet length in words, 1 up to a full page
    typedef logic [$clog2(`QS_WORDS_PER_PAGE+1)-1:0] word_cnt_t;

    // Packet or word length in bytes
    typedef logic [$clog2(`QS_MTU_BYTES+1)-1:0] byte_len_t;

    // Bytes held by one queue
    typedef logic [`QS_OCC_BITS-1:0] occupancy_t;

endpackage

`default_nettype wire

/* logic/page_ifc.sv */
//////////////////////////////
// Page events
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface page_ifc;
    import queue_states_pkg::*;

    // Allocate request from the tail side
    logic       alloc;
    queue_idx_t alloc_queue;
    logic       first_page;
    page_idx_t  prev_page;

    // Offer from the pool, valid every cycle
    page_idx_t  alloc_page;
    logic       pool_empty;

    // Page handed back by the head side
    logic       release_en;
    page_idx_t  release_page;

    modport tail (
        output alloc, alloc_queue, first_page, prev_page,
        input  alloc_page, pool_empty
    );

    modport pool (
        input  alloc, release_en, release_page,
        output alloc_page, pool_empty
    );

    modport head (
        input  alloc, alloc_queue, first_page, prev_page, alloc_page,
        output release_en, release_page
    );

endinterface

`default_nettype wire

/* logic/free_page_pool.sv */
//////////////////////////////
// Free page pool
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "queue_states_params.svh"

module free_page_pool (
    input logic clk,
    input logic reset,
    page_ifc.pool pages
);
    import queue_states_pkg::*;

    // One bit per page, set while the page is free
    logic [`QS_NUM_PAGES-1:0] free_map;

    //////////////////////////////
    // Allocation offer
    //////////////////////////////

    // Lowest free page wins
    always_comb begin
        pages.alloc_page = '0;
        for (int p = `QS_NUM_PAGES - 1; p >= 0; p--) begin
            if (free_map[p]) begin
                pages.alloc_page = page_idx_t'(p);
            end
        end
    end

    assign pages.pool_empty = ~|free_map;

    //////////////////////////////
    // Bitmap update
    //////////////////////////////

    // A released page is always owned, so it never equals the offered page
    always_ff @(posedge clk) begin
        if (reset) begin
            free_map <= '1;
        end else begin
            if (pages.alloc) begin
                free_map[pages.alloc_page] <= 1'b0;
            end
            if (pages.release_en) begin
                free_map[pages.release_page] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/tail_tracker.sv */
//////////////////////////////
// Enqueue tail tracking
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "queue_states_params.svh"

module tail_tracker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enq_valid,
    input  queue_states_pkg::queue_idx_t enq_queue,
    input  queue_states_pkg::byte_len_t  enq_bytes,
    page_ifc.tail                        pages,
    output logic                         accept,
    output logic                         drop,
    input  queue_states_pkg::queue_idx_t rd_queue,
    output queue_states_pkg::word_ptr_t  rd_tail_ptr,
    output queue_states_pkg::page_idx_t  rd_tail_page
);
    import queue_states_pkg::*;

    typedef logic [$bits(byte_len_t):0] bytes_ext_t;
    typedef logic [$bits(word_cnt_t):0] ptr_sum_t;

    localparam int WORD_SHIFT = $clog2(`QS_BYTES_PER_WORD);
    localparam bytes_ext_t ROUND_UP = bytes_ext_t'(`QS_BYTES_PER_WORD - 1);
    localparam ptr_sum_t PAGE_WORDS = ptr_sum_t'(`QS_WORDS_PER_PAGE);

    word_ptr_t                tail_ptr  [`QS_NUM_QUEUES];
    page_idx_t                tail_page [`QS_NUM_QUEUES];
    logic [`QS_NUM_QUEUES-1:0] has_page;

    bytes_ext_t bytes_round;
    word_cnt_t  word_cnt;
    ptr_sum_t   ptr_sum;
    logic       need_page;
    word_ptr_t  next_ptr;

    //////////////////////////////
    // Page decision
    //////////////////////////////

    always_comb begin
        // Ceiling division by the word size
        bytes_round = {1'b0, enq_bytes} + ROUND_UP;
        word_cnt    = word_cnt_t'(bytes_round >> WORD_SHIFT);
        ptr_sum     = ptr_sum_t'(tail_ptr[enq_queue]) + ptr_sum_t'(word_cnt);
        need_page   = !has_page[enq_queue] || (ptr_sum >= PAGE_WORDS);
        if (ptr_sum >= PAGE_WORDS) begin
            next_ptr = word_ptr_t'(ptr_sum - PAGE_WORDS);
        end else begin
            next_ptr = word_ptr_t'(ptr_sum);
        end
    end

    assign accept = enq_valid && !(need_page && pages.pool_empty);

    // Allocate request toward the pool and the head side
    assign pages.alloc       = accept && need_page;
    assign pages.alloc_queue = enq_queue;
    assign pages.first_page  = !has_page[enq_queue];
    assign pages.prev_page   = tail_page[enq_queue];

    //////////////////////////////
    // State registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            tail_ptr  <= '{default: '0};
            tail_page <= '{default: '0};
            has_page  <= '0;
            drop      <= 1'b0;
        end else begin
            drop <= enq_valid && need_page && pages.pool_empty;
            if (accept) begin
                tail_ptr[enq_queue] <= next_ptr;
                if (need_page) begin
                    tail_page[enq_queue] <= pages.alloc_page;
                    has_page[enq_queue]  <= 1'b1;
                end
            end
        end
    end

    assign rd_tail_ptr  = tail_ptr[rd_queue];
    assign rd_tail_page = tail_page[rd_queue];

endmodule

`default_nettype wire

/* logic/head_tracker.sv */
//////////////////////////////
// Dequeue head tracking
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "queue_states_params.svh"

module head_tracker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         deq_valid,
    input  queue_states_pkg::queue_idx_t deq_queue,
    page_ifc.head                        pages,
    input  queue_states_pkg::queue_idx_t rd_queue,
    output queue_states_pkg::word_ptr_t  rd_head_ptr,
    output queue_states_pkg::page_idx_t  rd_head_page
);
    import queue_states_pkg::*;

    localparam word_ptr_t LAST_WORD = word_ptr_t'(`QS_WORDS_PER_PAGE - 1);

    word_ptr_t head_ptr  [`QS_NUM_QUEUES];
    page_idx_t head_page [`QS_NUM_QUEUES];

    // Page chain, entry p holds the page that follows page p
    page_idx_t next_link [`QS_NUM_PAGES];

    logic      at_last_word;
    logic      link_write;
    page_idx_t next_page;

    assign at_last_word = head_ptr[deq_queue] == LAST_WORD;
    assign link_write   = pages.alloc && !pages.first_page;

    // Forward a link that is written in this same cycle
    always_comb begin
        if (link_write && pages.prev_page == head_page[deq_queue]) begin
            next_page = pages.alloc_page;
        end else begin
            next_page = next_link[head_page[deq_queue]];
        end
    end

    // Leaving the last word frees the page
    assign pages.release_en   = deq_valid && at_last_word;
    assign pages.release_page = head_page[deq_queue];

    //////////////////////////////
    // Link table
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (link_write) begin
            next_link[pages.prev_page] <= pages.alloc_page;
        end
    end

    //////////////////////////////
    // Head state
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            head_ptr  <= '{default: '0};
            head_page <= '{default: '0};
        end else begin
            // First page of a queue starts its chain
            if (pages.alloc && pages.first_page) begin
                head_page[pages.alloc_queue] <= pages.alloc_page;
            end
            if (deq_valid) begin
                head_ptr[deq_queue] <= head_ptr[deq_queue] + 1'b1;
                if (at_last_word) begin
                    head_page[deq_queue] <= next_page;
                end
            end
        end
    end

    assign rd_head_ptr  = head_ptr[rd_queue];
    assign rd_head_page = head_page[rd_queue];

endmodule

`default_nettype wire

/* logic/occupancy_table.sv */
//////////////////////////////
// Byte occupancy
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "queue_states_params.svh"

module occupancy_table (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         accept,
    input  queue_states_pkg::queue_idx_t enq_queue,
    input  queue_states_pkg::byte_len_t  enq_bytes,
    input  logic                         deq_valid,
    input  queue_states_pkg::queue_idx_t deq_queue,
    input  queue_states_pkg::byte_len_t  deq_bytes,
    input  queue_states_pkg::queue_idx_t rd_queue,
    output queue_states_pkg::occupancy_t rd_occupancy,
    output logic [`QS_NUM_QUEUES-1:0]    queue_empty
);
    import queue_states_pkg::*;

    occupancy_t occupancy [`QS_NUM_QUEUES];
    occupancy_t add_bytes [`QS_NUM_QUEUES];
    occupancy_t sub_bytes [`QS_NUM_QUEUES];

    // Per-queue deltas, an enqueue and a dequeue may hit one queue together
    always_comb begin
        for (int q = 0; q < `QS_NUM_QUEUES; q++) begin
            add_bytes[q] = '0;
            sub_bytes[q] = '0;
            if (accept && enq_queue == queue_idx_t'(q)) begin
                add_bytes[q] = occupancy_t'(enq_bytes);
            end
            if (deq_valid && deq_queue == queue_idx_t'(q)) begin
                sub_bytes[q] = occupancy_t'(deq_bytes);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= '{default: '0};
        end else begin
            for (int q = 0; q < `QS_NUM_QUEUES; q++) begin
                occupancy[q] <= occupancy[q] + add_bytes[q] - sub_bytes[q];
            end
        end
    end

    // Empty while no bytes are held
    always_comb begin
        for (int q = 0; q < `QS_NUM_QUEUES; q++) begin
            queue_empty[q] = occupancy[q] == '0;
        end
    end

    assign rd_occupancy = occupancy[rd_queue];

endmodule

`default_nettype wire

/* logic/queue_states_top.sv */
//////////////////////////////
// Queue state tracker
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "queue_states_params.svh"

module queue_states_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enq_valid,
    input  queue_states_pkg::queue_idx_t enq_queue,
    input  queue_states_pkg::byte_len_t  enq_bytes,
    input  logic                         deq_valid,
    input  queue_states_pkg::queue_idx_t deq_queue,
    input  queue_states_pkg::byte_len_t  deq_bytes,
    input  queue_states_pkg::queue_idx_t rd_queue,
    output logic [`QS_NUM_QUEUES-1:0]    queue_empty,
    output logic                         drop,
    output queue_states_pkg::occupancy_t rd_occupancy,
    output queue_states_pkg::word_ptr_t  rd_tail_ptr,
    output queue_states_pkg::page_idx_t  rd_tail_page,
    output queue_states_pkg::word_ptr_t  rd_head_ptr,
    output queue_states_pkg::page_idx_t  rd_head_page
);

    // Packet admitted by the tail side this cycle
    logic accept;

    page_ifc pages ();

    free_page_pool u_pool (
        .clk   (clk),
        .reset (reset),
        .pages (pages)
    );

    tail_tracker u_tail (
        .clk          (clk),
        .reset        (reset),
        .enq_valid    (enq_valid),
        .enq_queue    (enq_queue),
        .enq_bytes    (enq_bytes),
        .pages        (pages),
        .accept       (accept),
        .drop         (drop),
        .rd_queue     (rd_queue),
        .rd_tail_ptr  (rd_tail_ptr),
        .rd_tail_page (rd_tail_page)
    );

    head_tracker u_head (
        .clk          (clk),
        .reset        (reset),
        .deq_valid    (deq_valid),
        .deq_queue    (deq_queue),
        .pages        (pages),
        .rd_queue     (rd_queue),
        .rd_head_ptr  (rd_head_ptr),
        .rd_head_page (rd_head_page)
    );

    occupancy_table u_occupancy (
        .clk          (clk),
        .reset        (reset),
        .accept       (accept),
        .enq_queue    (enq_queue),
        .enq_bytes    (enq_bytes),
        .deq_valid    (deq_valid),
        .deq_queue    (deq_queue),
        .deq_bytes    (deq_bytes),
        .rd_queue     (rd_queue),
        .rd_occupancy (rd_occupancy),
        .queue_empty  (queue_empty)
    );

endmodule

`default_nettype wire

/* verification/queue_states_chk.sv */
//////////////////////////////
// Queue state assertions
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "queue_states_params.svh"

module queue_states_chk (
    input logic                         clk,
    input logic                         reset,
    input logic                         drop,
    input queue_states_pkg::queue_idx_t rd_queue,
    input queue_states_pkg::occupancy_t rd_occupancy,
    input logic [`QS_NUM_QUEUES-1:0]    queue_empty
);

    // Count of failed assertions
    int fail_count = 0;

    // A drop is a single-cycle pulse
    a_drop_single: assert property (@(posedge clk) disable iff (reset)
        drop |=> !drop)
        else begin
            $error("drop held high for more than one cycle");
            fail_count++;
        end

    // The dropped packet never added bytes
    a_drop_no_add: assert property (@(posedge clk) disable iff (reset)
        (drop && $stable(rd_queue)) |-> (rd_occupancy <= $past(rd_occupancy)))
        else begin
            $error("occupancy rose in the same cycle as a drop");
            fail_count++;
        end

    a_empty_after_reset: assert property (@(posedge clk)
        ($past(reset) && !reset) |-> &queue_empty)
        else begin
            $error("queue_empty not all ones after reset");
            fail_count++;
        end

endmodule

bind queue_states_top queue_states_chk u_chk (
    .clk          (clk),
    .reset        (reset),
    .drop         (drop),
    .rd_queue     (rd_queue),
    .rd_occupancy (rd_occupancy),
    .queue_empty  (queue_empty)
);

`default_nettype wire

/* verification/queue_states_checker.sv */
//////////////////////////////
// Queue state reference model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "queue_states_params.svh"

module queue_states_checker (
    input logic                         clk,
    input logic                         reset,
    input logic                         enq_valid,
    input queue_states_pkg::queue_idx_t enq_queue,
    input queue_states_pkg::byte_len_t  enq_bytes,
    input logic                         deq_valid,
    input queue_states_pkg::queue_idx_t deq_queue,
    input queue_states_pkg::byte_len_t  deq_bytes,
    input queue_states_pkg::queue_idx_t rd_queue,
    input logic [`QS_NUM_QUEUES-1:0]    queue_empty,
    input logic                         drop,
    input queue_states_pkg::occupancy_t rd_occupancy,
    input queue_states_pkg::word_ptr_t  rd_tail_ptr,
    input queue_states_pkg::page_idx_t  rd_tail_page,
    input queue_states_pkg::word_ptr_t  rd_head_ptr,
    input queue_states_pkg::page_idx_t  rd_head_page
);
    import queue_states_pkg::*;

    localparam int NQ = `QS_NUM_QUEUES;
    localparam int NP = `QS_NUM_PAGES;
    localparam int WPP = `QS_WORDS_PER_PAGE;
    localparam int BPW = `QS_BYTES_PER_WORD;
    localparam int MAX_WORDS = `QS_NUM_PAGES * `QS_WORDS_PER_PAGE;

    // Model state per queue
    int occ       [NQ];
    int tail_ptr  [NQ];
    int tail_page [NQ];
    bit has_page  [NQ];
    int head_ptr  [NQ];
    int head_page [NQ];
    int link      [NP];
    bit free_map  [NP];
    bit exp_drop;

    // Byte count of every stored word, read by the stimulus
    int word_bytes [NQ][MAX_WORDS];
    int wr_idx     [NQ];
    int rd_idx     [NQ];
    int word_total [NQ];

    int error_count;
    int drop_count;
    int low_free;
    int sel;

    //////////////////////////////
    // Reference rules
    //////////////////////////////

    function automatic int word_count(input int bytes);
        return (bytes + BPW - 1) / BPW;
    endfunction

    function automatic int lowest_free();
        for (int p = 0; p < NP; p++) begin
            if (free_map[p]) begin
                return p;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic reset_model();
        for (int q = 0; q < NQ; q++) begin
            occ[q] = 0;
            tail_ptr[q] = 0;
            tail_page[q] = 0;
            has_page[q] = 0;
            head_ptr[q] = 0;
            head_page[q] = 0;
            wr_idx[q] = 0;
            rd_idx[q] = 0;
            word_total[q] = 0;
        end
        for (int p = 0; p < NP; p++) begin
            free_map[p] = 1;
        end
        exp_drop = 0;
    endtask

    task automatic apply_enqueue(input int q, input int bytes);
        int wc;
        int sum;
        bit need;
        wc = word_count(bytes);
        sum = tail_ptr[q] + wc;
        need = !has_page[q] || (sum >= WPP);
        if (need && low_free < 0) begin
            exp_drop = 1;
            drop_count++;
            return;
        end
        occ[q] += bytes;
        tail_ptr[q] = sum % WPP;
        if (need) begin
            if (!has_page[q]) begin
                head_page[q] = low_free;
            end else begin
                link[tail_page[q]] = low_free;
            end
            tail_page[q] = low_free;
            has_page[q] = 1;
            free_map[low_free] = 0;
        end
        // Full words, then the remainder in the last one
        for (int i = 0; i < wc; i++) begin
            word_bytes[q][wr_idx[q]] = (i == wc - 1) ? bytes - BPW * (wc - 1) : BPW;
            wr_idx[q] = (wr_idx[q] + 1) % MAX_WORDS;
            word_total[q]++;
        end
    endtask

    task automatic apply_dequeue(input int q, input int bytes);
        if (word_total[q] == 0) begin
            $display("Dequeue issued to queue %0d which holds no words", q);
            error_count++;
            return;
        end
        occ[q] -= bytes;
        if (head_ptr[q] == WPP - 1) begin
            free_map[head_page[q]] = 1;
            head_page[q] = link[head_page[q]];
        end
        head_ptr[q] = (head_ptr[q] + 1) % WPP;
        rd_idx[q] = (rd_idx[q] + 1) % MAX_WORDS;
        word_total[q]--;
    endtask

    //////////////////////////////
    // Compare, then advance model
    //////////////////////////////

    initial begin
        error_count = 0;
        drop_count = 0;
        reset_model();
    end

    always @(posedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            sel = int'(rd_queue);
            check_value("drop", int'(drop), int'(exp_drop));
            for (int q = 0; q < NQ; q++) begin
                check_value($sformatf("queue_empty[%0d]", q), int'(queue_empty[q]),
                            int'(occ[q] == 0));
            end
            check_value("rd_occupancy", int'(rd_occupancy), occ[sel]);
            check_value("rd_tail_ptr", int'(rd_tail_ptr), tail_ptr[sel]);
            check_value("rd_tail_page", int'(rd_tail_page), tail_page[sel]);
            check_value("rd_head_ptr", int'(rd_head_ptr), head_ptr[sel]);
            check_value("rd_head_page", int'(rd_head_page), head_page[sel]);

            // Pool is sampled before this cycle's release
            low_free = lowest_free();
            exp_drop = 0;
            if (enq_valid) begin
                apply_enqueue(int'(enq_queue), int'(enq_bytes));
            end
            if (deq_valid) begin
                apply_dequeue(int'(deq_queue), int'(deq_bytes));
            end
        end
    end

endmodule

`default_nettype wire

/* verification/queue_states_tb.sv */
//////////////////////////////
// Queue state testbench
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "queue_states_params.svh"

module queue_states_tb;
    import queue_states_pkg::*;

    localparam int NQ = `QS_NUM_QUEUES;
    localparam int DRAIN_LIMIT = 3000;
    localparam int FILL_LIMIT = 400;

    integer seed = 32'h75bc8a58;

    logic                core_clk_ifc;
    logic                reset;
    logic                enq_valid;
    queue_idx_t          enq_queue;
    byte_len_t           enq_bytes;
    logic                deq_valid;
    queue_idx_t          deq_queue;
    byte_len_t           deq_bytes;
    queue_idx_t          rd_queue;
    logic [NQ-1:0]       queue_empty;
    logic                drop;
    occupancy_t          rd_occupancy;
    word_ptr_t           rd_tail_ptr;
    page_idx_t           rd_tail_page;
    word_ptr_t           rd_head_ptr;
    page_idx_t           rd_head_page;

    int timeout_count;
    int steps;
    int pick;
    int drops_before;

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    queue_states_top DUT (
        .clk          (core_clk_ifc),
        .reset        (reset),
        .enq_valid    (enq_valid),
        .enq_queue    (enq_queue),
        .enq_bytes    (enq_bytes),
        .deq_valid    (deq_valid),
        .deq_queue    (deq_queue),
        .deq_bytes    (deq_bytes),
        .rd_queue     (rd_queue),
        .queue_empty  (queue_empty),
        .drop         (drop),
        .rd_occupancy (rd_occupancy),
        .rd_tail_ptr  (rd_tail_ptr),
        .rd_tail_page (rd_tail_page),
        .rd_head_ptr  (rd_head_ptr),
        .rd_head_page (rd_head_page)
    );

    queue_states_checker u_checker (
        .clk          (core_clk_ifc),
        .reset        (reset),
        .enq_valid    (enq_valid),
        .enq_queue    (enq_queue),
        .enq_bytes    (enq_bytes),
        .deq_valid    (deq_valid),
        .deq_queue    (deq_queue),
        .deq_bytes    (deq_bytes),
        .rd_queue     (rd_queue),
        .queue_empty  (queue_empty),
        .drop         (drop),
        .rd_occupancy (rd_occupancy),
        .rd_tail_ptr  (rd_tail_ptr),
        .rd_tail_page (rd_tail_page),
        .rd_head_ptr  (rd_head_ptr),
        .rd_head_page (rd_head_page)
    );

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    // Random non-empty queue in the model, or -1
    function automatic int pick_nonempty();
        int start;
        start = rand_range(0, NQ - 1);
        for (int i = 0; i < NQ; i++) begin
            if (u_checker.word_total[(start + i) % NQ] > 0) begin
                return (start + i) % NQ;
            end
        end
        return -1;
    endfunction

    function automatic byte_len_t front_word(input int q);
        return byte_len_t'(u_checker.word_bytes[q][u_checker.rd_idx[q]]);
    endfunction

    // One event cycle, then an idle cycle so the model settles
    task automatic drive_event(input logic ev, input int eq, input int eb,
                               input logic dv, input int dq, input int db);
        @(posedge core_clk_ifc);
        enq_valid <= ev;
        enq_queue <= queue_idx_t'(eq);
        enq_bytes <= byte_len_t'(eb);
        deq_valid <= dv;
        deq_queue <= queue_idx_t'(dq);
        deq_bytes <= byte_len_t'(db);
        // Read back the touched queue before and after the event
        rd_queue  <= ev ? queue_idx_t'(eq) : queue_idx_t'(dq);
        @(posedge core_clk_ifc);
        enq_valid <= 1'b0;
        deq_valid <= 1'b0;
        @(negedge core_clk_ifc);
    endtask

    task automatic enqueue_random();
        drive_event(1'b1, rand_range(0, NQ - 1),
                    rand_range(`QS_MIN_BYTES, `QS_MTU_BYTES), 1'b0, 0, 0);
    endtask

    task automatic dequeue_word(input int q);
        drive_event(1'b0, 0, 0, 1'b1, q, int'(front_word(q)));
    endtask

    // Enqueue and dequeue on one queue in the same cycle
    task automatic enq_deq_same(input int q);
        drive_event(1'b1, q, rand_range(`QS_MIN_BYTES, `QS_MTU_BYTES),
                    1'b1, q, int'(front_word(q)));
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        timeout_count = 0;
        reset     = 1'b1;
        enq_valid = 1'b0;
        enq_queue = '0;
        enq_bytes = '0;
        deq_valid = 1'b0;
        deq_queue = '0;
        deq_bytes = '0;
        rd_queue  = '0;

        repeat (10) @(posedge core_clk_ifc);
        reset <= 1'b0;

        // Readback of every queue after reset
        for (int q = 0; q < NQ; q++) begin
            @(posedge core_clk_ifc);
            rd_queue <= queue_idx_t'(q);
        end
        @(negedge core_clk_ifc);

        // Mixed traffic
        repeat (400) begin
            pick = pick_nonempty();
            case (rand_range(0, 3))
                0, 1: enqueue_random();
                2: begin
                    if (pick >= 0) begin
                        dequeue_word(pick);
                    end else begin
                        enqueue_random();
                    end
                end
                default: begin
                    if (pick >= 0) begin
                        enq_deq_same(pick);
                    end else begin
                        enqueue_random();
                    end
                end
            endcase
        end

        // Drain every queue
        steps = 0;
        while (pick_nonempty() >= 0 && steps < DRAIN_LIMIT) begin
            dequeue_word(pick_nonempty());
            steps++;
        end
        if (steps >= DRAIN_LIMIT) begin
            $display("Timeout while draining the queues");
            timeout_count++;
        end

        // Fill without dequeues until the pool runs dry
        drops_before = u_checker.drop_count;
        steps = 0;
        while (u_checker.drop_count - drops_before < 4 && steps < FILL_LIMIT) begin
            enqueue_random();
            steps++;
        end
        if (steps >= FILL_LIMIT) begin
            $display("Timeout waiting for the pool to run out of pages");
            timeout_count++;
        end

        repeat (2) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        $display("Error counts: %0d value, %0d assertion, %0d timeout",
                 u_checker.error_count, DUT.u_chk.fail_count, timeout_count);
        if (u_checker.error_count == 0 && DUT.u_chk.fail_count == 0
                && timeout_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
logic/queue_states_pkg.sv
logic/page_ifc.sv
logic/free_page_pool.sv
logic/tail_tracker.sv
logic/head_tracker.sv
logic/occupancy_table.sv
logic/queue_states_top.sv
verification/queue_states_chk.sv
verification/queue_states_checker.sv
verification/queue_states_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the queue state tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module queue_states_tb \
    -Mdir obj_dir \
    && ./obj_dir/Vqueue_states_tb | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
